//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module sdram_tb -o Vsdram_tb

run: build
	@out=$$(./obj_dir/Vsdram_tb 2>&1); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module sdram_tb

clean:
	rm -rf obj_dir

//--- all.f
verilog/sdram_timing_pkg.sv
verilog/sdram_cmd_pkg.sv
verilog/sdram_fifo.sv
verilog/sdram_sequencer.sv
verilog/sdram_write.sv
verilog/sdram_read.sv
verilog/sdram_ctrl.sv
dv/sdram_model.sv
dv/sdram_chk.sv
dv/sdram_tb.sv

//--- dv/sdram_chk.sv
// ====================================================================
// sdram protocol checker
// assertions on the command pins, bound into the controller top
// ====================================================================
`timescale 1ns/1ps

module sdram_chk (
	input logic clk,
	input logic rst,
	input logic cke,
	input logic cs_n,
	input logic ras_n,
	input logic cas_n,
	input logic we_n
);

	logic [2:0] cmd;
	logic       mrs_seen;
	// cycles since the last activate, saturating
	int         since_act;

	assign cmd = cs_n ? sdram_cmd_pkg::cmd_nop : {ras_n, cas_n, we_n};

	always_ff @(posedge clk) begin
		if (rst) begin
			mrs_seen <= 1'b0;
			since_act <= 100;
		end else begin
			if (cmd == sdram_cmd_pkg::cmd_mrs) mrs_seen <= 1'b1;
			if (cmd == sdram_cmd_pkg::cmd_act) since_act <= 1;
			else if (since_act < 100) since_act <= since_act + 1;
		end
	end

	// rows open only once the mode register is loaded
	act_after_mrs: assert property (@(posedge clk) disable iff (rst)
		cmd == sdram_cmd_pkg::cmd_act |-> mrs_seen)
		else $error("ACT issued before the mode register set");

	cke_low_after_reset: assert property (@(posedge clk) rst |=> !cke)
		else $error("cke high in the first cycle after reset");

	// column command waits t_rcd after the activate
	rcd_met: assert property (@(posedge clk) disable iff (rst)
		(cmd == sdram_cmd_pkg::cmd_rd || cmd == sdram_cmd_pkg::cmd_wr)
		|-> since_act >= sdram_timing_pkg::t_rcd)
		else $error("READ or WRITE issued sooner than t_rcd after ACT");

endmodule

bind sdram_ctrl sdram_chk u_chk (
	.clk(clk),
	.rst(rst),
	.cke(cke),
	.cs_n(cs_n),
	.ras_n(ras_n),
	.cas_n(cas_n),
	.we_n(we_n)
);

//--- dv/sdram_model.sv
// ====================================================================
// sdram model
// behavioral 16 bit SDRAM, decodes commands on clk, keeps beats per
// bank, row and column with byte masks, answers reads after cas latency
// ====================================================================
`timescale 1ns/1ps

module sdram_model (
	input  logic        clk,
	input  logic        cke,
	input  logic        cs_n,
	input  logic        ras_n,
	input  logic        cas_n,
	input  logic        we_n,
	input  logic [11:0] addr,
	input  logic [1:0]  bank,
	inout  wire  [15:0] data,
	input  logic [1:0]  data_mask,
	output logic        order_err,
	output logic [2:0]  init_step
);

	// sparse storage keyed by {bank, row, column}
	logic [15:0] mem [logic [22:0]];
	logic [11:0] open_row [4];
	logic [2:0]  cmd;
	logic [22:0] wr_key;
	logic        wr_second;
	logic [22:0] rd_key;
	int          rd_stage;
	logic [15:0] dq_out;
	logic        dq_oe;

	// deselected or clock disabled counts as nop
	assign cmd = (cs_n || !cke) ? sdram_cmd_pkg::cmd_nop : {ras_n, cas_n, we_n};
	assign data = dq_oe ? dq_out : 16'hzzzz;

	// beat column is the even burst column plus the beat number
	function automatic logic [22:0] beat_key(input logic [1:0] b, input logic [8:0] col,
		input logic beat);
		return {b, open_row[b], col[8:1], beat};
	endfunction

	function automatic logic [15:0] stored(input logic [22:0] k);
		if (mem.exists(k)) return mem[k];
		return 16'h0000;
	endfunction

	// dqm high keeps the old byte
	function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] nw,
		input logic [1:0] dqm);
		logic [15:0] r;
		r = old;
		if (!dqm[0]) r[7:0] = nw[7:0];
		if (!dqm[1]) r[15:8] = nw[15:8];
		return r;
	endfunction

	// power-up order is precharge, refresh, refresh, mode set
	function automatic logic [2:0] init_cmd(input logic [2:0] step);
		case (step)
			3'd0: return sdram_cmd_pkg::cmd_pre;
			3'd3: return sdram_cmd_pkg::cmd_mrs;
			default: return sdram_cmd_pkg::cmd_ar;
		endcase
	endfunction

	initial begin
		order_err = 1'b0;
		init_step = 3'd0;
		wr_second = 1'b0;
		rd_stage = 0;
		dq_oe = 1'b0;
		dq_out = 16'h0000;
	end

	always @(posedge clk) begin : decode
		logic [22:0] k;
		if (init_step < 3'd4 && cmd != sdram_cmd_pkg::cmd_nop) begin
			if (cmd == init_cmd(init_step)) init_step <= init_step + 3'd1;
			else order_err <= 1'b1;
		end
		if (cmd == sdram_cmd_pkg::cmd_act) open_row[bank] <= addr;
		// second write beat arrives one cycle after the WRITE
		if (wr_second) begin
			mem[wr_key] = merge(stored(wr_key), data, data_mask);
			wr_second <= 1'b0;
		end
		if (cmd == sdram_cmd_pkg::cmd_wr) begin
			k = beat_key(bank, addr[8:0], 1'b0);
			mem[k] = merge(stored(k), data, data_mask);
			wr_key <= k | 23'd1;
			wr_second <= 1'b1;
		end
		if (cmd == sdram_cmd_pkg::cmd_rd) begin
			rd_key <= beat_key(bank, addr[8:0], 1'b0);
			rd_stage <= 1;
		end else if (rd_stage != 0) begin
			// each beat goes out one cycle before the controller samples it
			if (rd_stage == sdram_timing_pkg::cas_lat - 1) begin
				dq_out <= stored(rd_key);
				dq_oe <= 1'b1;
			end else if (rd_stage == sdram_timing_pkg::cas_lat) begin
				dq_out <= stored(rd_key | 23'd1);
			end else begin
				dq_oe <= 1'b0;
			end
			rd_stage <= (rd_stage == sdram_timing_pkg::cas_lat + 1) ? 0 : rd_stage + 1;
		end
	end

endmodule

//--- dv/sdram_tb.sv
// ====================================================================
// sdram controller testbench
// replays write and read records from the trace file against the
// controller and a behavioral SDRAM, checks init and refresh
// ====================================================================
`timescale 1ns/1ps

module sdram_tb;

	localparam int wait_limit = 2000;
	localparam int init_cycles = sdram_timing_pkg::t_powerup + sdram_timing_pkg::t_rp +
		2 * sdram_timing_pkg::t_rfc + sdram_timing_pkg::t_mrd + 4;
	// write queue entries in the controller
	localparam int wr_q_depth = 16;

	logic        clk;
	logic        rst;
	logic        wr_fifo_wr;
	logic [31:0] wr_fifo_data;
	logic [3:0]  wr_fifo_mask;
	logic        wr_fifo_full;
	logic        rd_fifo_rd;
	logic [31:0] rd_fifo_data;
	logic        rd_fifo_empty;
	logic        write_en;
	logic        read_en;
	logic [21:0] address;
	logic        sdram_ready;
	logic        cke;
	logic        cs_n;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [11:0] addr;
	logic [1:0]  bank;
	wire  [15:0] data;
	logic [1:0]  data_mask;
	logic        order_err;
	logic [2:0]  init_step;

	int fd;
	int seed = 32'h7502;
	// pin level counters
	int wr_cmds = 0;
	int ar_count = 0;
	int ready_cycles = 0;
	int words_pushed = 0;

	sdram_ctrl sdram_ctrl_i (.*);

	sdram_model u_model (
		.clk(clk), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
		.addr(addr), .bank(bank), .data(data), .data_mask(data_mask),
		.order_err(order_err), .init_step(init_step)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// WRITE and refresh commands seen at the pins
	always @(posedge clk) begin
		if (!cs_n && {ras_n, cas_n, we_n} == sdram_cmd_pkg::cmd_wr) wr_cmds++;
		if (sdram_ready) begin
			ready_cycles++;
			if (!cs_n && {ras_n, cas_n, we_n} == sdram_cmd_pkg::cmd_ar) ar_count++;
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Error: %s expected %h actual %h",
				name, expected, actual));
		end
	endtask

	// next record letter, skipping comment lines
	task automatic read_kind(output byte kind);
		int c;
		byte ch;
		logic in_comment;
		kind = 8'd0;
		in_comment = 1'b0;
		c = $fgetc(fd);
		while (c != -1 && kind == 8'd0) begin
			ch = byte'(c);
			if (in_comment) begin
				if (ch == "\n") in_comment = 1'b0;
			end else if (ch == "#") begin
				in_comment = 1'b1;
			end else if (ch == "W" || ch == "R" || ch == "E") begin
				kind = ch;
			end
			if (kind == 8'd0) c = $fgetc(fd);
		end
	endtask

	task automatic push_word(input logic [31:0] d, input logic [3:0] m);
		int n;
		n = 0;
		while (wr_fifo_full && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (wr_fifo_full) stop_with_failure("timeout waiting for room in the write queue");
		wr_fifo_wr = 1'b1;
		wr_fifo_data = d;
		wr_fifo_mask = m;
		@(negedge clk);
		wr_fifo_wr = 1'b0;
	endtask

	task automatic write_record(input logic [21:0] a, input int count);
		logic [31:0] d;
		logic [31:0] m;
		int n;
		for (int i = 0; i < count; i++) begin
			if ($fscanf(fd, "%h %h", d, m) != 2) stop_with_failure("malformed W record in trace");
			push_word(d, m[3:0]);
		end
		// queue holds only this record, full once every entry is taken
		compare_value("wr_fifo_full", {31'd0, count == wr_q_depth}, {31'd0, wr_fifo_full});
		words_pushed += count;
		address = a;
		write_en = 1'b1;
		@(negedge clk);
		write_en = 1'b0;
		n = 0;
		while (wr_cmds < words_pushed && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (wr_cmds < words_pushed) begin
			stop_with_failure($sformatf("timeout waiting for the WRITE commands to %h", a));
		end
		// engine idle again after write recovery and precharge
		repeat (sdram_timing_pkg::t_wr + sdram_timing_pkg::t_rp + 2) @(negedge clk);
	endtask

	task automatic read_record(input logic [21:0] a, input logic [31:0] expected);
		int n;
		address = a;
		read_en = 1'b1;
		@(negedge clk);
		read_en = 1'b0;
		n = 0;
		while (rd_fifo_empty && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (rd_fifo_empty) stop_with_failure($sformatf("timeout waiting for read data from %h", a));
		compare_value($sformatf("read %h", a), expected, rd_fifo_data);
		rd_fifo_rd = 1'b1;
		@(negedge clk);
		rd_fifo_rd = 1'b0;
	endtask

	task automatic idle_gap();
		int g;
		g = $unsigned($random(seed)) % 24;
		repeat (g) @(negedge clk);
	endtask

	initial begin
		byte kind;
		logic done;
		logic [31:0] a;
		logic [31:0] expected;
		int cnt;
		int n;
		int min_ref;
		logic [31:0] ref_ok;
		rst = 1'b1;
		wr_fifo_wr = 1'b0;
		wr_fifo_data = '0;
		wr_fifo_mask = '0;
		rd_fifo_rd = 1'b0;
		write_en = 1'b0;
		read_en = 1'b0;
		address = '0;
		fd = $fopen("dv/sdram_trace.txt", "r");
		if (fd == 0) stop_with_failure("cannot open the trace file dv/sdram_trace.txt");
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// power-up sequence has a fixed length
		n = 0;
		while (!sdram_ready && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!sdram_ready) stop_with_failure("timeout waiting for sdram_ready after reset");
		compare_value("init_cycles", init_cycles, n);
		compare_value("init_commands", 32'd4, {29'd0, init_step});
		compare_value("init_order", 32'd0, {31'd0, order_err});

		done = 1'b0;
		while (!done) begin
			read_kind(kind);
			case (kind)
				"W": begin
					if ($fscanf(fd, "%h %d", a, cnt) != 2) stop_with_failure("malformed W record");
					write_record(a[21:0], cnt);
				end
				"R": begin
					if ($fscanf(fd, "%h %h", a, expected) != 2) stop_with_failure("malformed R record");
					read_record(a[21:0], expected);
				end
				"E": done = 1'b1;
				default: stop_with_failure("trace ended without an E record");
			endcase
			if (!done) idle_gap();
		end
		$fclose(fd);

		// idle long enough for the refresh timer to matter
		repeat (2 * sdram_timing_pkg::t_refi) @(negedge clk);
		min_ref = ready_cycles / sdram_timing_pkg::t_refi - 1;
		ref_ok = (ar_count >= min_ref) ? 32'd1 : 32'd0;
		compare_value("refresh_count", 32'd1, ref_ok);
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- dv/sdram_trace.txt
# W addr count then count pairs of data word and byte mask, mask bit 1 writes the byte
# R addr expected_word and E ends the trace, all values hex except count
W 000010 4 11112222 f 33334444 f 55556666 f 77778888 f
R 000010 11112222
R 000011 33334444
R 000012 55556666
R 000013 77778888
W 000011 2 aabbccdd 5 deadbeef a
R 000011 33bb44dd
R 000012 de55be66
W 100510 1 0badf00d f
W 200510 1 cafe0001 f
W 3abcff 1 12345678 f
W 07ff10 1 fedcba98 f
R 100510 0badf00d
R 200510 cafe0001
R 3abcff 12345678
R 07ff10 fedcba98
R 000010 11112222
R 000013 77778888
E

//--- verilog/sdram_cmd_pkg.sv
// ====================================================================
// sdram commands
// command encodings, mode register and address word layout
// ====================================================================

package sdram_cmd_pkg;

	// {ras_n, cas_n, we_n}
	localparam logic [2:0] cmd_nop = 3'b111;
	localparam logic [2:0] cmd_act = 3'b011;
	localparam logic [2:0] cmd_rd = 3'b101;
	localparam logic [2:0] cmd_wr = 3'b100;
	localparam logic [2:0] cmd_pre = 3'b010;
	localparam logic [2:0] cmd_ar = 3'b001;
	localparam logic [2:0] cmd_mrs = 3'b000;

	// burst length 2, sequential, cas latency 2, burst writes
	localparam logic [11:0] mode_reg = 12'h021;

	// one pin word, read as a row by ACT and as a column by READ/WRITE
	typedef union packed {
		logic [11:0] row;
		struct packed {
			logic       spare_hi;
			logic       ap;
			logic       spare_lo;
			logic [7:0] word;
			// beat select, bursts always start on the even column
			logic       pad;
		} col;
	} sdram_addr_u;

	// 22 bit user word address is {bank, row, word column}
	localparam int bank_msb = 21;
	localparam int row_lsb = 8;
	localparam int col_lsb = 0;

	function automatic sdram_addr_u row_word(input logic [21:0] a);
		sdram_addr_u w;
		w.row = a[row_lsb +: 12];
		return w;
	endfunction

	// column word with auto precharge set
	function automatic sdram_addr_u col_word(input logic [21:0] a);
		sdram_addr_u w;
		w = '0;
		w.col.ap = 1'b1;
		w.col.word = a[col_lsb +: 8];
		return w;
	endfunction

	function automatic logic [1:0] bank_of(input logic [21:0] a);
		return a[bank_msb -: 2];
	endfunction

endpackage

//--- verilog/sdram_ctrl.sv
// ====================================================================
// sdram controller top
// host queues, sequencer and both engines around a 16 bit SDRAM
// ====================================================================
`timescale 1ns/1ps

module sdram_ctrl (
	input  logic        clk,
	input  logic        rst,
	input  logic        wr_fifo_wr,
	input  logic [31:0] wr_fifo_data,
	input  logic [3:0]  wr_fifo_mask,
	output logic        wr_fifo_full,
	input  logic        rd_fifo_rd,
	output logic [31:0] rd_fifo_data,
	output logic        rd_fifo_empty,
	input  logic        write_en,
	input  logic        read_en,
	input  logic [21:0] address,
	output logic        sdram_ready,
	output logic        cke,
	output logic        cs_n,
	output logic        ras_n,
	output logic        cas_n,
	output logic        we_n,
	output logic [11:0] addr,
	output logic [1:0]  bank,
	inout  wire  [15:0] data,
	output logic [1:0]  data_mask
);

	// write queue side, {mask, data}
	logic [35:0] wr_q_dout;
	logic        wr_q_empty;
	logic        wr_q_pop;
	// read queue side
	logic [31:0] rd_q_din;
	logic        rd_q_push;
	logic        rd_q_full;
	// grant handshake
	logic        wr_req;
	logic        rd_req;
	logic        wr_start;
	logic        rd_start;
	logic        wr_done;
	logic        rd_done;
	// engine command buses
	logic [2:0]  wr_cmd;
	logic [11:0] wr_addr;
	logic [1:0]  wr_bank;
	logic [2:0]  rd_cmd;
	logic [11:0] rd_addr;
	logic [1:0]  rd_bank;
	logic [15:0] wr_dq;
	logic        wr_dq_oe;

	// only the write engine ever drives the bus
	assign data = wr_dq_oe ? wr_dq : 16'hzzzz;

	sdram_fifo #(.width(36), .depth_log2(4)) u_wr_q (
		.clk(clk), .rst(rst),
		.push(wr_fifo_wr), .din({wr_fifo_mask, wr_fifo_data}),
		.pop(wr_q_pop), .dout(wr_q_dout),
		.full(wr_fifo_full), .empty(wr_q_empty)
	);

	sdram_fifo #(.width(32), .depth_log2(2)) u_rd_q (
		.clk(clk), .rst(rst),
		.push(rd_q_push), .din(rd_q_din),
		.pop(rd_fifo_rd), .dout(rd_fifo_data),
		.full(rd_q_full), .empty(rd_fifo_empty)
	);

	sdram_sequencer u_seq (
		.clk(clk), .rst(rst),
		.wr_req(wr_req), .rd_req(rd_req), .rd_fifo_full(rd_q_full),
		.wr_done(wr_done), .rd_done(rd_done),
		.wr_cmd(wr_cmd), .wr_addr(wr_addr), .wr_bank(wr_bank),
		.rd_cmd(rd_cmd), .rd_addr(rd_addr), .rd_bank(rd_bank),
		.wr_start(wr_start), .rd_start(rd_start), .sdram_ready(sdram_ready),
		.cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n),
		.addr(addr), .bank(bank)
	);

	sdram_write u_write (
		.clk(clk), .rst(rst),
		.write_en(write_en), .address(address), .start(wr_start),
		.fifo_dout(wr_q_dout), .fifo_empty(wr_q_empty), .fifo_pop(wr_q_pop),
		.req(wr_req), .done(wr_done),
		.cmd(wr_cmd), .addr(wr_addr), .bank(wr_bank),
		.dq(wr_dq), .dq_oe(wr_dq_oe), .dqm(data_mask)
	);

	sdram_read u_read (
		.clk(clk), .rst(rst),
		.read_en(read_en), .address(address), .start(rd_start), .dq(data),
		.req(rd_req), .done(rd_done),
		.cmd(rd_cmd), .addr(rd_addr), .bank(rd_bank),
		.fifo_push(rd_q_push), .fifo_din(rd_q_din)
	);

endmodule

//--- verilog/sdram_fifo.sv
// ====================================================================
// sdram fifo
// synchronous first-word-fall-through queue with full and empty
// ====================================================================
`timescale 1ns/1ps

module sdram_fifo #(
	parameter int width = 32,
	parameter int depth_log2 = 2
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [width-1:0] din,
	input  logic             pop,
	output logic [width-1:0] dout,
	output logic             full,
	output logic             empty
);

	logic [width-1:0]    mem [2**depth_log2];
	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	// one extra bit so a full queue is distinct from an empty one
	logic [depth_log2:0] count;
	logic                do_push;
	logic                do_pop;

	// push into a full queue or pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = count[depth_log2];
	assign empty = (count == '0);
	// head entry always visible
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// count only moves when exactly one side is active
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/sdram_read.sv
// ====================================================================
// sdram read engine
// one pending word: activate, read with auto precharge, then two
// beats captured after the cas latency and pushed as one word
// ====================================================================
`timescale 1ns/1ps

module sdram_read (
	input  logic        clk,
	input  logic        rst,
	input  logic        read_en,
	input  logic [21:0] address,
	input  logic        start,
	input  logic [15:0] dq,
	output logic        req,
	output logic        done,
	output logic [2:0]  cmd,
	output logic [11:0] addr,
	output logic [1:0]  bank,
	output logic        fifo_push,
	output logic [31:0] fifo_din
);

	logic [21:0] rd_addr_q;
	logic        pend;
	logic        busy;
	logic [3:0]  step;
	logic [15:0] lo;
	logic        rd_go;
	logic        cap_lo;
	logic        cap_hi;

	assign req = pend;

	assign rd_go = busy && (step == 4'(sdram_timing_pkg::t_rcd - 1));
	// first beat sits on dq cas_lat cycles after the READ cycle
	assign cap_lo = busy && (step == 4'(sdram_timing_pkg::t_rcd + sdram_timing_pkg::cas_lat));
	assign cap_hi = busy && (step == 4'(sdram_timing_pkg::t_rcd + sdram_timing_pkg::cas_lat + 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			busy <= 1'b0;
			step <= '0;
			cmd <= sdram_cmd_pkg::cmd_nop;
			fifo_push <= 1'b0;
			done <= 1'b0;
		end else begin
			cmd <= sdram_cmd_pkg::cmd_nop;
			fifo_push <= 1'b0;
			done <= 1'b0;
			// a new request while one is pending is dropped
			if (read_en && !pend) pend <= 1'b1;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
				cmd <= sdram_cmd_pkg::cmd_act;
			end else if (busy) begin
				step <= step + 4'd1;
			end
			if (rd_go) cmd <= sdram_cmd_pkg::cmd_rd;
			// precharge is over by the time the second beat is in
			if (cap_hi) begin
				fifo_push <= 1'b1;
				done <= 1'b1;
				busy <= 1'b0;
				pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_en && !pend) rd_addr_q <= address;
		if (start) begin
			addr <= sdram_cmd_pkg::row_word(rd_addr_q);
			bank <= sdram_cmd_pkg::bank_of(rd_addr_q);
		end
		if (rd_go) addr <= sdram_cmd_pkg::col_word(rd_addr_q);
		if (cap_lo) lo <= dq;
		// low half came first
		if (cap_hi) fifo_din <= {dq, lo};
	end

endmodule

//--- verilog/sdram_sequencer.sv
// ====================================================================
// sdram sequencer
// power-up sequence, refresh timer and command bus arbitration
// between initialization, the write engine and the read engine
// ====================================================================
`timescale 1ns/1ps

module sdram_sequencer (
	input  logic        clk,
	input  logic        rst,
	input  logic        wr_req,
	input  logic        rd_req,
	input  logic        rd_fifo_full,
	input  logic        wr_done,
	input  logic        rd_done,
	input  logic [2:0]  wr_cmd,
	input  logic [11:0] wr_addr,
	input  logic [1:0]  wr_bank,
	input  logic [2:0]  rd_cmd,
	input  logic [11:0] rd_addr,
	input  logic [1:0]  rd_bank,
	output logic        wr_start,
	output logic        rd_start,
	output logic        sdram_ready,
	output logic        cke,
	output logic        cs_n,
	output logic        ras_n,
	output logic        cas_n,
	output logic        we_n,
	output logic [11:0] addr,
	output logic [1:0]  bank
);

	// init steps first, then the steady states
	localparam logic [3:0] st_pwr = 4'd0;
	localparam logic [3:0] st_ar1 = 4'd1;
	localparam logic [3:0] st_ar2 = 4'd2;
	localparam logic [3:0] st_mrs = 4'd3;
	localparam logic [3:0] st_mrd = 4'd4;
	localparam logic [3:0] st_ready = 4'd5;
	localparam logic [3:0] st_write = 4'd6;
	localparam logic [3:0] st_read = 4'd7;
	localparam logic [3:0] st_refresh = 4'd8;

	logic [3:0]  state;
	logic [15:0] delay;
	logic [2:0]  init_cmd;
	logic [11:0] init_addr;
	logic [$clog2(sdram_timing_pkg::t_refi)-1:0] ref_cnt;
	logic        ref_due;
	logic        ref_issue;

	// refresh wins over any grant and only starts from an idle bus
	assign ref_issue = (state == st_ready) && (delay == '0) && ref_due;

	// free running refresh interval counter
	always_ff @(posedge clk) begin
		if (rst) begin
			ref_cnt <= '0;
			ref_due <= 1'b0;
		end else if (ref_cnt == ($bits(ref_cnt))'(sdram_timing_pkg::t_refi - 1)) begin
			ref_cnt <= '0;
			ref_due <= 1'b1;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			if (ref_issue) begin
				ref_due <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_pwr;
			delay <= 16'(sdram_timing_pkg::t_powerup);
			cke <= 1'b0;
			cs_n <= 1'b1;
			init_cmd <= sdram_cmd_pkg::cmd_nop;
			init_addr <= '0;
			sdram_ready <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
		end else begin
			// commands and grants are one cycle pulses
			init_cmd <= sdram_cmd_pkg::cmd_nop;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			if (delay != '0) begin
				delay <= delay - 1'b1;
			end else begin
				case (state)
					st_pwr: begin
						// clock enable on, precharge all banks via a10
						cke <= 1'b1;
						cs_n <= 1'b0;
						init_cmd <= sdram_cmd_pkg::cmd_pre;
						init_addr <= 12'h400;
						delay <= 16'(sdram_timing_pkg::t_rp);
						state <= st_ar1;
					end
					st_ar1: begin
						init_cmd <= sdram_cmd_pkg::cmd_ar;
						delay <= 16'(sdram_timing_pkg::t_rfc);
						state <= st_ar2;
					end
					st_ar2: begin
						init_cmd <= sdram_cmd_pkg::cmd_ar;
						delay <= 16'(sdram_timing_pkg::t_rfc);
						state <= st_mrs;
					end
					st_mrs: begin
						init_cmd <= sdram_cmd_pkg::cmd_mrs;
						init_addr <= sdram_cmd_pkg::mode_reg;
						delay <= 16'(sdram_timing_pkg::t_mrd - 1);
						state <= st_mrd;
					end
					st_mrd: begin
						sdram_ready <= 1'b1;
						state <= st_ready;
					end
					st_ready: begin
						// refresh, then write, then read
						if (ref_issue) begin
							init_cmd <= sdram_cmd_pkg::cmd_ar;
							delay <= 16'(sdram_timing_pkg::t_rfc);
							state <= st_refresh;
						end else if (wr_req) begin
							wr_start <= 1'b1;
							state <= st_write;
						end else if (rd_req && !rd_fifo_full) begin
							rd_start <= 1'b1;
							state <= st_read;
						end
					end
					st_write: if (wr_done) state <= st_ready;
					st_read: if (rd_done) state <= st_ready;
					// t_rfc already counted down
					st_refresh: state <= st_ready;
					default: state <= st_pwr;
				endcase
			end
		end
	end

	// pins follow the owner of the bus
	always_comb begin
		case (state)
			st_write: begin
				{ras_n, cas_n, we_n} = wr_cmd;
				addr = wr_addr;
				bank = wr_bank;
			end
			st_read: begin
				{ras_n, cas_n, we_n} = rd_cmd;
				addr = rd_addr;
				bank = rd_bank;
			end
			default: begin
				{ras_n, cas_n, we_n} = init_cmd;
				addr = init_addr;
				bank = 2'b00;
			end
		endcase
	end

endmodule

//--- verilog/sdram_timing_pkg.sv
// ====================================================================
// sdram timing
// SDRAM timing constants, all counted in clk cycles
// ====================================================================

package sdram_timing_pkg;

	// wait after reset before the first command
	// shortened for simulation, a real part needs 100 us or more
	localparam int t_powerup = 100;

	// precharge to next command
	localparam int t_rp = 2;
	// auto refresh cycle time
	localparam int t_rfc = 7;
	// mode register set to next command
	localparam int t_mrd = 2;
	// activate to read or write
	localparam int t_rcd = 2;
	// last write beat to precharge (write recovery)
	localparam int t_wr = 2;
	// read command to first data beat
	localparam int cas_lat = 2;
	// one auto refresh is due this often
	localparam int t_refi = 390;

endpackage

//--- verilog/sdram_write.sv
// ====================================================================
// sdram write engine
// one queued word per grant: activate, then a two beat write with
// auto precharge, low half first
// ====================================================================
`timescale 1ns/1ps

module sdram_write (
	input  logic        clk,
	input  logic        rst,
	input  logic        write_en,
	input  logic [21:0] address,
	input  logic        start,
	input  logic [35:0] fifo_dout,
	input  logic        fifo_empty,
	output logic        fifo_pop,
	output logic        req,
	output logic        done,
	output logic [2:0]  cmd,
	output logic [11:0] addr,
	output logic [1:0]  bank,
	output logic [15:0] dq,
	output logic        dq_oe,
	output logic [1:0]  dqm
);

	logic [21:0] word_addr;
	// set by write_en, dropped once the queue drains
	logic        armed;
	logic        busy;
	// step k is visible k+1 cycles after start
	logic [3:0]  step;
	logic        wr_go;
	logic        beat2;
	logic        fin;

	assign req = armed && !fifo_empty;

	assign wr_go = busy && (step == 4'(sdram_timing_pkg::t_rcd - 1));
	assign beat2 = busy && (step == 4'(sdram_timing_pkg::t_rcd));
	// auto precharge after t_wr, then t_rp before the bank is idle
	assign fin = busy && (step == 4'(sdram_timing_pkg::t_rcd + sdram_timing_pkg::t_wr +
		sdram_timing_pkg::t_rp));

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			busy <= 1'b0;
			step <= '0;
			cmd <= sdram_cmd_pkg::cmd_nop;
			fifo_pop <= 1'b0;
			done <= 1'b0;
			dq_oe <= 1'b0;
			dqm <= 2'b00;
		end else begin
			cmd <= sdram_cmd_pkg::cmd_nop;
			fifo_pop <= 1'b0;
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
				cmd <= sdram_cmd_pkg::cmd_act;
			end else if (busy) begin
				step <= step + 4'd1;
			end
			if (wr_go) begin
				cmd <= sdram_cmd_pkg::cmd_wr;
				fifo_pop <= 1'b1;
				dq_oe <= 1'b1;
				// mask bit 1 writes the byte, dqm high blocks it
				dqm <= ~fifo_dout[33:32];
			end
			if (beat2) begin
				dqm <= ~fifo_dout[35:34];
			end
			if (busy && (step == 4'(sdram_timing_pkg::t_rcd + 1))) begin
				dq_oe <= 1'b0;
				dqm <= 2'b00;
			end
			if (fin) begin
				done <= 1'b1;
				busy <= 1'b0;
				if (fifo_empty) armed <= 1'b0;
			end
			if (write_en) armed <= 1'b1;
		end
	end

	// address and data path
	always_ff @(posedge clk) begin
		if (start) begin
			addr <= sdram_cmd_pkg::row_word(word_addr);
			bank <= sdram_cmd_pkg::bank_of(word_addr);
		end
		if (wr_go) begin
			addr <= sdram_cmd_pkg::col_word(word_addr);
			dq <= fifo_dout[15:0];
		end
		// head is still the same word here, the pop lands on this edge
		if (beat2) begin
			dq <= fifo_dout[31:16];
			word_addr <= word_addr + 22'd1;
		end
		if (write_en) word_addr <= address;
	end

endmodule
